// ==== allbitp_tx.sv ====
`timescale 1ns/1ps
`include "bt_tx_macros.svh"

module allbitp_tx import bt_tx_pkg::*; (
  input  logic       clk_6M,
  input  logic       rstz,
  input  logic       p_1us,
  input  logic       tx_packet_st_p,
  input  bt_header_t hdr,
  input  logic [7:0] regi_uap,
  input  logic [5:0] clk_slot,
  input  logic       regi_txwhitening,
  input  logic [5:0] regi_payloadlen,
  input  buf_wr_t    host_wr,
  output logic       txbit,
  output logic       txbit_period,
  output logic       txbit_period_endp,
  output logic       py_endp
);

  pktype_info_t info;
  logic [$clog2(`BT_MAX_PYBYTES)-1:0] byte_addr;
  logic [7:0] byte_data;
  logic load, hdr_shift, py_shift, wh_step;
  logic hdr_bit, hdr_last, py_bit, py_last, wh_bit;

  pktype_decode u_pktype_decode (
    .pk_type         (hdr.pk_type),
    .regi_payloadlen (regi_payloadlen),
    .info            (info)
  );

  tx_payload_buf u_tx_payload_buf (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .host_wr   (host_wr),
    .byte_addr (byte_addr),
    .byte_data (byte_data)
  );

  whitening_lfsr u_whitening_lfsr (
    .clk_6M   (clk_6M),
    .rstz     (rstz),
    .load     (load),
    .wh_step  (wh_step),
    .clk_slot (clk_slot),
    .wh_bit   (wh_bit)
  );

  header_bitp u_header_bitp (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .load      (load),
    .hdr_shift (hdr_shift),
    .hdr       (hdr),
    .regi_uap  (regi_uap),
    .hdr_bit   (hdr_bit),
    .hdr_last  (hdr_last)
  );

  payload_bitp u_payload_bitp (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .load      (load),
    .py_shift  (py_shift),
    .info      (info),
    .regi_uap  (regi_uap),
    .byte_data (byte_data),
    .byte_addr (byte_addr),
    .py_bit    (py_bit),
    .py_last   (py_last)
  );

  tx_sequencer u_tx_sequencer (
    .clk_6M            (clk_6M),
    .rstz              (rstz),
    .p_1us             (p_1us),
    .tx_packet_st_p    (tx_packet_st_p),
    .info              (info),
    .regi_txwhitening  (regi_txwhitening),
    .hdr_bit           (hdr_bit),
    .hdr_last          (hdr_last),
    .py_bit            (py_bit),
    .py_last           (py_last),
    .wh_bit            (wh_bit),
    .load              (load),
    .hdr_shift         (hdr_shift),
    .py_shift          (py_shift),
    .wh_step           (wh_step),
    .txbit             (txbit),
    .txbit_period      (txbit_period),
    .txbit_period_endp (txbit_period_endp),
    .py_endp           (py_endp)
  );

endmodule

// ==== bt_tx_macros.svh ====
`ifndef BT_TX_MACROS_SVH
`define BT_TX_MACROS_SVH

// packet header and HEC
`define BT_HDR_BITS     10
`define BT_HEC_BITS     8
`define BT_HEC_POLY     8'hA7
`define BT_FEC13_REP    3

// payload CRC, CCITT
`define BT_CRC_BITS     16
`define BT_CRC_POLY     16'h1021

`define BT_WHITEN_BITS  7

// tx payload buffer
`define BT_BUF_WORDS    8
`define BT_BUF_AW       3
`define BT_MAX_PYBYTES  32
`define BT_PYBIT_W      9

`endif

// ==== bt_tx_pkg.sv ====
`include "bt_tx_macros.svh"

package bt_tx_pkg;

  typedef enum logic [3:0] {
    PK_NULL = 4'd0,
    PK_POLL = 4'd1,
    PK_DH1  = 4'd4,
    PK_AUX1 = 4'd9
  } pk_type_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HEADER,
    ST_PAYLOAD
  } tx_state_e;

  // first field sits at the msb, so lt_addr[0] ends up at bit 0 and goes out first
  typedef struct packed {
    logic     seqn;
    logic     arqn;
    logic     flow;
    pk_type_e pk_type;
    logic [2:0] lt_addr;
  } bt_header_t;

  typedef struct packed {
    logic                   has_payload;
    logic                   has_crc;
    logic [`BT_PYBIT_W-1:0] pylenbit;    // payload bits, crc not counted
  } pktype_info_t;

  typedef struct packed {
    logic                  we;
    logic [`BT_BUF_AW-1:0] addr;
    logic [31:0]           din;
  } buf_wr_t;

endpackage

// ==== header_bitp.sv ====
`timescale 1ns/1ps
`include "bt_tx_macros.svh"

module header_bitp import bt_tx_pkg::*; (
  input  logic       clk_6M,
  input  logic       rstz,
  input  logic       load,
  input  logic       hdr_shift,
  input  bt_header_t hdr,
  input  logic [7:0] regi_uap,
  output logic       hdr_bit,
  output logic       hdr_last
);

  localparam int HDR_TOTAL = `BT_HDR_BITS + `BT_HEC_BITS;

  logic [`BT_HDR_BITS-1:0]   hdr_sr;
  logic [`BT_HEC_BITS-1:0]   hec_reg;
  logic [4:0]                bit_cnt;
  logic [1:0]                rep;
  logic                      in_hdr;
  logic                      rep_done;
  logic                      hec_fb;

  assign in_hdr   = (bit_cnt < `BT_HDR_BITS);
  assign rep_done = (rep == `BT_FEC13_REP - 1);
  assign hec_fb   = hdr_sr[0] ^ hec_reg[`BT_HEC_BITS-1];

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      bit_cnt <= '0;
      rep     <= '0;
    end
    else if (load)
    begin
      bit_cnt <= '0;
      rep     <= '0;
    end
    else if (hdr_shift)
    begin
      rep <= rep_done ? 2'd0 : rep + 2'd1;
      if (rep_done)
        bit_cnt <= bit_cnt + 5'd1;
    end
  end

  // data moves only after the third copy of a bit
  always_ff @(posedge clk_6M)
  begin
    if (load)
    begin
      hdr_sr  <= hdr;
      hec_reg <= regi_uap;
    end
    else if (hdr_shift && rep_done)
    begin
      if (in_hdr)
      begin
        hdr_sr  <= hdr_sr >> 1;
        hec_reg <= {hec_reg[`BT_HEC_BITS-2:0], 1'b0} ^ (hec_fb ? `BT_HEC_POLY : 8'h00);
      end
      else
        hec_reg <= {hec_reg[`BT_HEC_BITS-2:0], 1'b0};
    end
  end

  assign hdr_bit  = in_hdr ? hdr_sr[0] : hec_reg[`BT_HEC_BITS-1];
  assign hdr_last = (bit_cnt == HDR_TOTAL - 1) && rep_done;

endmodule

// ==== payload_bitp.sv ====
`timescale 1ns/1ps
`include "bt_tx_macros.svh"

module payload_bitp import bt_tx_pkg::*; (
  input  logic                               clk_6M,
  input  logic                               rstz,
  input  logic                               load,
  input  logic                               py_shift,
  input  pktype_info_t                       info,
  input  logic [7:0]                         regi_uap,
  input  logic [7:0]                         byte_data,
  output logic [$clog2(`BT_MAX_PYBYTES)-1:0] byte_addr,
  output logic                               py_bit,
  output logic                               py_last
);

  localparam int BA_W = $clog2(`BT_MAX_PYBYTES);

  logic [`BT_PYBIT_W-1:0]  bit_cnt;
  logic [`BT_PYBIT_W-1:0]  total_bits;
  logic [`BT_CRC_BITS-1:0] crc_reg;
  logic                    in_data;
  logic                    data_bit;
  logic                    crc_fb;

  assign total_bits = info.pylenbit + (info.has_crc ? `BT_PYBIT_W'(`BT_CRC_BITS) : '0);
  assign in_data    = (bit_cnt < info.pylenbit);

  assign byte_addr = bit_cnt[BA_W+2:3];
  assign data_bit  = byte_data[bit_cnt[2:0]];   // lsb first
  assign crc_fb    = data_bit ^ crc_reg[`BT_CRC_BITS-1];

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      bit_cnt <= '0;
    else if (load)
      bit_cnt <= '0;
    else if (py_shift)
      bit_cnt <= bit_cnt + 1'b1;
  end

  always_ff @(posedge clk_6M)
  begin
    if (load)
      crc_reg <= {8'h00, regi_uap};
    else if (py_shift)
    begin
      if (in_data)
        crc_reg <= {crc_reg[`BT_CRC_BITS-2:0], 1'b0} ^
                   (crc_fb ? `BT_CRC_POLY : 16'h0000);
      else
        crc_reg <= {crc_reg[`BT_CRC_BITS-2:0], 1'b0};  // crc out, msb first
    end
  end

  assign py_bit  = in_data ? data_bit : crc_reg[`BT_CRC_BITS-1];
  assign py_last = (bit_cnt == total_bits - 1'b1);

endmodule

// ==== pktype_decode.sv ====
`timescale 1ns/1ps
`include "bt_tx_macros.svh"

module pktype_decode import bt_tx_pkg::*; (
  input  pk_type_e     pk_type,
  input  logic [5:0]   regi_payloadlen,
  output pktype_info_t info
);

  localparam logic [5:0] DH1_MAXBYTES  = 6'd27;
  localparam logic [5:0] AUX1_MAXBYTES = 6'd29;

  logic [5:0] pybytes;

  always_comb
  begin
    info.has_crc = 1'b0;
    pybytes      = '0;
    case (pk_type)
      PK_DH1:
      begin
        info.has_crc = 1'b1;
        pybytes = (regi_payloadlen > DH1_MAXBYTES) ? DH1_MAXBYTES : regi_payloadlen;
      end
      PK_AUX1:
      begin
        pybytes = (regi_payloadlen > AUX1_MAXBYTES) ? AUX1_MAXBYTES : regi_payloadlen;
      end
      default: ; // header only for NULL, POLL and unused codes
    endcase
    info.pylenbit = {pybytes, 3'b000};
    // DH1 of length 0 still sends its crc
    info.has_payload = (pybytes != '0) || info.has_crc;
  end

endmodule

// ==== src.f ====
+incdir+.
bt_tx_pkg.sv
pktype_decode.sv
tx_payload_buf.sv
whitening_lfsr.sv
header_bitp.sv
payload_bitp.sv
tx_sequencer.sv
allbitp_tx.sv
tb_txbit_checker.sv
tb_allbitp_tx.sv

// ==== tb_allbitp_tx.sv ====
`timescale 1ns/1ps
`include "bt_tx_macros.svh"

module tb_allbitp_tx import bt_tx_pkg::*; ();

  localparam int MAX_CYCLES = 12 * 300 * 6 + 200;   // 12 packets of up to 300 bits

  logic       clk_6M = 1'b0;
  logic       rstz;
  logic       p_1us;
  logic       tx_packet_st_p;
  bt_header_t hdr;
  logic [7:0] regi_uap;
  logic [5:0] clk_slot;
  logic       regi_txwhitening;
  logic [5:0] regi_payloadlen;
  buf_wr_t    host_wr;
  logic       txbit;
  logic       txbit_period;
  logic       txbit_period_endp;
  logic       py_endp;

  logic [31:0] lfsr_state;
  logic [6:0]  model_wh;
  int          div_cnt   = 0;
  int          cycle_cnt = 0;

  // fields of the packet under test
  logic [3:0]  cur_type;
  logic [2:0]  cur_lt;
  logic        cur_flow;
  logic        cur_arqn;
  logic        cur_seqn;
  logic        cur_whiten;
  logic [7:0]  cur_uap;
  logic [5:0]  cur_slot;
  logic [5:0]  cur_len;
  logic [7:0]  py_data [32];

  allbitp_tx u_dut (.*);

  tb_txbit_checker u_checker (.*);

  always #20 clk_6M = ~clk_6M;

  always @(posedge clk_6M)
  begin
    #2;
    div_cnt = (div_cnt == 5) ? 0 : div_cnt + 1;
    p_1us   = (div_cnt == 5);
  end

  always @(posedge clk_6M)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES)
    begin
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic tick();
    @(posedge clk_6M);
    #2;
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  task automatic random_fields();
    cur_lt   = rand_bits(3);
    cur_flow = rand_bits(1);
    cur_arqn = rand_bits(1);
    cur_seqn = rand_bits(1);
    cur_uap  = rand_bits(8);
    cur_slot = rand_bits(6);
    cur_len  = rand_bits(6);
    for (int i = 0; i < 32; i++)
      py_data[i] = rand_bits(8);
  endtask

  task automatic model_bit(input logic d, input int reps);
    logic b;
    b = d ^ (cur_whiten & model_wh[6]);
    repeat (reps) u_checker.push_bit(b);
    model_wh = {model_wh[5:0], model_wh[6] ^ model_wh[3]};   // x^7 + x^4 + 1
  endtask

  task automatic build_expected();
    logic [9:0]  hbits;
    logic [7:0]  hec;
    logic [15:0] crc;
    logic        fb;
    logic        has_crc;
    int          nbytes;
    hbits   = {cur_seqn, cur_arqn, cur_flow, cur_type, cur_lt};   // lt_addr[0] goes first
    has_crc = (cur_type == PK_DH1);
    if (cur_type == PK_DH1)
      nbytes = (cur_len > 27) ? 27 : cur_len;
    else if (cur_type == PK_AUX1)
      nbytes = (cur_len > 29) ? 29 : cur_len;
    else
      nbytes = 0;
    u_checker.expect_packet(54 + 8 * nbytes + (has_crc ? 16 : 0), has_crc || nbytes != 0);
    model_wh = {1'b1, cur_slot};
    hec = cur_uap;
    for (int i = 0; i < 10; i++)
    begin
      fb  = hbits[i] ^ hec[7];
      hec = {hec[6:0], 1'b0} ^ (fb ? `BT_HEC_POLY : 8'h00);
      model_bit(hbits[i], 3);
    end
    for (int i = 7; i >= 0; i--)
      model_bit(hec[i], 3);
    crc = {8'h00, cur_uap};
    for (int k = 0; k < nbytes; k++)
    begin
      for (int i = 0; i < 8; i++)
      begin
        fb  = py_data[k][i] ^ crc[15];
        crc = {crc[14:0], 1'b0} ^ (fb ? `BT_CRC_POLY : 16'h0000);
        model_bit(py_data[k][i], 1);
      end
    end
    if (has_crc)
    begin
      for (int i = 15; i >= 0; i--)
        model_bit(crc[i], 1);
    end
  endtask

  task automatic write_buffer();
    for (int w = 0; w < 8; w++)
    begin
      host_wr.we   = 1'b1;
      host_wr.addr = w[2:0];
      host_wr.din  = {py_data[4*w+3], py_data[4*w+2], py_data[4*w+1], py_data[4*w]};
      tick();
    end
    host_wr.we = 1'b0;
  endtask

  task automatic run_packet(input string name, input logic mid_start);
    int wait_cnt;
    hdr.lt_addr      = cur_lt;
    hdr.pk_type      = pk_type_e'(cur_type);
    hdr.flow         = cur_flow;
    hdr.arqn         = cur_arqn;
    hdr.seqn         = cur_seqn;
    regi_uap         = cur_uap;
    clk_slot         = cur_slot;
    regi_txwhitening = cur_whiten;
    regi_payloadlen  = cur_len;
    write_buffer();
    u_checker.start_test(name);
    build_expected();
    tx_packet_st_p = 1'b1;
    tick();
    tx_packet_st_p = 1'b0;
    if (mid_start)
    begin
      while (!txbit_period)
        tick();
      repeat (150) tick();   // about 25 bits in, still in the header
      tx_packet_st_p = 1'b1;
      tick();
      tx_packet_st_p = 1'b0;
    end
    wait_cnt = 0;
    while (!u_checker.pkt_done && wait_cnt < (u_checker.exp_len + 4) * 6)
    begin
      tick();
      wait_cnt++;
    end
    repeat (14) tick();
    u_checker.end_test();
  endtask

  initial
  begin
    lfsr_state       = 32'hde99;
    rstz             = 1'b0;
    p_1us            = 1'b0;
    tx_packet_st_p   = 1'b0;
    hdr              = '0;
    regi_uap         = '0;
    clk_slot         = '0;
    regi_txwhitening = 1'b0;
    regi_payloadlen  = '0;
    host_wr          = '0;
    repeat (10) @(posedge clk_6M);
    #2;
    rstz = 1'b1;

    u_checker.start_test("reset_idle");
    repeat (12)
    begin
      u_checker.check_idle();
      tick();
    end
    u_checker.end_test();

    random_fields();
    cur_type   = PK_NULL;
    cur_whiten = 1'b0;
    run_packet("null_random", 1'b0);
    random_fields();
    cur_type = PK_POLL;
    run_packet("poll_random", 1'b0);

    for (int i = 0; i < 3; i++)
    begin
      random_fields();
      cur_type   = PK_DH1;
      cur_whiten = 1'b1;
      cur_len    = 6'(rand_bits(5) % 27 + 1);
      run_packet($sformatf("dh1_random_%0d", i), 1'b0);
    end

    random_fields();
    cur_type = PK_AUX1;
    cur_len  = 6'(30 + rand_bits(5));
    run_packet("aux1_clamp", 1'b0);
    random_fields();
    cur_type = PK_DH1;
    cur_len  = 6'(28 + rand_bits(5));
    run_packet("dh1_clamp", 1'b0);
    random_fields();
    cur_len = '0;
    run_packet("dh1_len0", 1'b0);

    // one DH1 under different whitening settings
    random_fields();
    cur_len = 6'(rand_bits(5) % 27 + 1);
    run_packet("dh1_whiten_on", 1'b0);
    cur_whiten = 1'b0;
    run_packet("dh1_whiten_off", 1'b0);
    cur_whiten = 1'b1;
    cur_slot   = cur_slot ^ 6'h2b;
    run_packet("dh1_other_slot", 1'b0);

    random_fields();
    cur_len = 6'(rand_bits(5) % 27 + 1);
    run_packet("mid_start_ignored", 1'b1);

    $display("%0d tests run, %0d passed, %0d failed", u_checker.test_cnt,
             u_checker.test_cnt - u_checker.fail_cnt, u_checker.fail_cnt);
    if (u_checker.fail_cnt == 0 && u_checker.err_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== tb_txbit_checker.sv ====
`timescale 1ns/1ps

module tb_txbit_checker (
  input logic clk_6M,
  input logic rstz,
  input logic p_1us,
  input logic txbit,
  input logic txbit_period,
  input logic txbit_period_endp,
  input logic py_endp
);

  string test_name = "none";
  logic  exp_q[$];
  logic  exp_bit;
  logic  exp_py   = 1'b0;
  logic  test_err = 1'b0;
  logic  pkt_done = 1'b0;
  int    exp_len  = 0;
  int    exp_endp = 0;
  int    bit_cnt  = 0;
  int    endp_cnt = 0;
  int    mism_cnt = 0;
  int    test_cnt = 0;
  int    fail_cnt = 0;
  int    err_cnt  = 0;

  task automatic report_value(input string what, input int exp_v, input int act_v);
    $display("[FAIL] %s %s expected %0d actual %0d", test_name, what, exp_v, act_v);
    test_err = 1'b1;
    err_cnt++;
  endtask

  task automatic report_error(input string msg);
    $display("error in %s: %s", test_name, msg);
    test_err = 1'b1;
    err_cnt++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    exp_q.delete();
    exp_len  = 0;
    exp_endp = 0;
    exp_py   = 1'b0;
    bit_cnt  = 0;
    endp_cnt = 0;
    mism_cnt = 0;
    test_err = 1'b0;
    pkt_done = 1'b0;
  endtask

  task automatic expect_packet(input int len, input logic py);
    exp_len  = len;
    exp_py   = py;
    exp_endp = 1;
  endtask

  task automatic push_bit(input logic b);
    exp_q.push_back(b);
  endtask

  task automatic check_idle();
    if (txbit !== 1'b0)
      report_value("txbit", 0, txbit);
    if (txbit_period !== 1'b0)
      report_value("txbit_period", 0, txbit_period);
    if (txbit_period_endp !== 1'b0)
      report_value("txbit_period_endp", 0, txbit_period_endp);
    if (py_endp !== 1'b0)
      report_value("py_endp", 0, py_endp);
  endtask

  task automatic end_test();
    if (exp_endp == 1 && endp_cnt == 0)
      report_error("no txbit_period_endp arrived for the packet");
    else if (endp_cnt != exp_endp)
      report_error($sformatf("%0d end pulses seen where %0d was due", endp_cnt, exp_endp));
    check_idle();
    test_cnt++;
    if (test_err)
    begin
      fail_cnt++;
      $display("test %s: errors found", test_name);
    end
    else
      $display("test %s: ok, %0d bits", test_name, bit_cnt);
  endtask

  // txbit holds the bit sent since the previous p_1us
  always @(posedge clk_6M)
  begin
    if (rstz && p_1us && txbit_period)
    begin
      if (exp_q.size() == 0)
      begin
        if (bit_cnt == exp_len)
          report_error($sformatf("txbit carried bits beyond the expected %0d", exp_len));
      end
      else
      begin
        exp_bit = exp_q.pop_front();
        if (txbit !== exp_bit)
        begin
          mism_cnt++;
          if (mism_cnt <= 3)
            report_value($sformatf("bit %0d", bit_cnt), exp_bit, txbit);
          else
            test_err = 1'b1;
        end
      end
      bit_cnt++;
    end
    if (rstz && txbit_period_endp)
    begin
      endp_cnt++;
      pkt_done = 1'b1;
      if (bit_cnt != exp_len)
        report_value("packet length", exp_len, bit_cnt);
      if (py_endp !== exp_py)
        report_value("py_endp", exp_py, py_endp);
    end
    else if (rstz && py_endp)
      report_error("py_endp pulsed without txbit_period_endp");
  end

endmodule

// ==== tx_payload_buf.sv ====
`timescale 1ns/1ps
`include "bt_tx_macros.svh"

module tx_payload_buf import bt_tx_pkg::*; (
  input  logic                               clk_6M,
  input  logic                               rstz,
  input  buf_wr_t                            host_wr,
  input  logic [$clog2(`BT_MAX_PYBYTES)-1:0] byte_addr,
  output logic [7:0]                         byte_data
);

  logic [31:0] mem [`BT_BUF_WORDS];

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      for (int i = 0; i < `BT_BUF_WORDS; i++)
        mem[i] <= '0;
    end
    else if (host_wr.we)
    begin
      mem[host_wr.addr] <= host_wr.din;
    end
  end

  // byte 0 is bits 7:0 of word 0
  assign byte_data = mem[byte_addr[$clog2(`BT_MAX_PYBYTES)-1:2]][8*byte_addr[1:0] +: 8];

endmodule

// ==== tx_sequencer.sv ====
`timescale 1ns/1ps
`include "bt_tx_macros.svh"

module tx_sequencer import bt_tx_pkg::*; (
  input  logic         clk_6M,
  input  logic         rstz,
  input  logic         p_1us,
  input  logic         tx_packet_st_p,
  input  pktype_info_t info,
  input  logic         regi_txwhitening,
  input  logic         hdr_bit,
  input  logic         hdr_last,
  input  logic         py_bit,
  input  logic         py_last,
  input  logic         wh_bit,
  output logic         load,
  output logic         hdr_shift,
  output logic         py_shift,
  output logic         wh_step,
  output logic         txbit,
  output logic         txbit_period,
  output logic         txbit_period_endp,
  output logic         py_endp
);

  tx_state_e  state;
  logic [1:0] rep;
  logic       raw_bit;
  logic       tx_next;

  // start only from a fully idle machine, busy pulses are dropped
  assign load      = (state == ST_IDLE) && !txbit_period && tx_packet_st_p;
  assign hdr_shift = p_1us && (state == ST_HEADER);
  assign py_shift  = p_1us && (state == ST_PAYLOAD);
  assign wh_step   = py_shift || (hdr_shift && rep == `BT_FEC13_REP - 1);

  assign raw_bit = (state == ST_PAYLOAD) ? py_bit : hdr_bit;
  assign tx_next = raw_bit ^ (regi_txwhitening & wh_bit);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state             <= ST_IDLE;
      rep               <= '0;
      txbit             <= 1'b0;
      txbit_period      <= 1'b0;
      txbit_period_endp <= 1'b0;
      py_endp           <= 1'b0;
    end
    else
    begin
      txbit_period_endp <= 1'b0;
      py_endp           <= 1'b0;
      if (load)
      begin
        state <= ST_HEADER;
        rep   <= '0;
      end
      else if (p_1us)
      begin
        case (state)
          ST_HEADER:
          begin
            txbit        <= tx_next;
            txbit_period <= 1'b1;
            rep          <= (rep == `BT_FEC13_REP - 1) ? 2'd0 : rep + 2'd1;
            if (hdr_last)
              state <= info.has_payload ? ST_PAYLOAD : ST_IDLE;
          end
          ST_PAYLOAD:
          begin
            txbit <= tx_next;
            if (py_last)
              state <= ST_IDLE;
          end
          default:
          begin
            // idle with period still high: last bit just went out
            if (txbit_period)
            begin
              txbit             <= 1'b0;
              txbit_period      <= 1'b0;
              txbit_period_endp <= 1'b1;
              py_endp           <= info.has_payload;
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== whitening_lfsr.sv ====
`timescale 1ns/1ps
`include "bt_tx_macros.svh"

module whitening_lfsr (
  input  logic       clk_6M,
  input  logic       rstz,
  input  logic       load,
  input  logic       wh_step,
  input  logic [5:0] clk_slot,   // CLK[6:1]
  output logic       wh_bit
);

  logic [`BT_WHITEN_BITS-1:0] wh_reg;

  // x^7 + x^4 + 1, fibonacci form
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      wh_reg <= '0;
    else if (load)
      wh_reg <= {1'b1, clk_slot};
    else if (wh_step)
      wh_reg <= {wh_reg[`BT_WHITEN_BITS-2:0], wh_reg[6] ^ wh_reg[3]};
  end

  assign wh_bit = wh_reg[`BT_WHITEN_BITS-1];

endmodule
